//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = lcdControllerTb
FILELIST  = project.f
BUILDDIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP)

clean:
	rm -rf $(BUILDDIR)

//--- project.f
rtl/lcdPkg.sv
rtl/lcdByteIf.sv
rtl/lcdAxiRegs.sv
rtl/lcdCommandSequencer.sv
rtl/lcdByteFifo.sv
rtl/lcdBusWriter.sv
rtl/lcdController.sv
testbench/lcdControllerTb.sv

//--- rtl/lcdAxiRegs.sv
`timescale 1ns/10ps

module lcdAxiRegs (
    input  logic                              clk,
    input  logic                              rst,
    // Write address and data
    input  logic [lcdPkg::axiAddrWidth-1:0]   awAddr,
    input  logic                              awValid,
    output logic                              awReady,
    input  logic [lcdPkg::axiDataWidth-1:0]   wData,
    input  logic [lcdPkg::axiDataWidth/8-1:0] wStrb,
    input  logic                              wValid,
    output logic                              wReady,
    output logic [1:0]                        bResp,
    output logic                              bValid,
    input  logic                              bReady,
    // Read
    input  logic [lcdPkg::axiAddrWidth-1:0]   arAddr,
    input  logic                              arValid,
    output logic                              arReady,
    output logic [lcdPkg::axiDataWidth-1:0]   rData,
    output logic [1:0]                        rResp,
    output logic                              rValid,
    input  logic                              rReady,
    // Sequencer request
    output logic                              reqValid,
    output lcdPkg::reqKind_e                  reqKind,
    output logic [31:0]                       reqWord,
    output logic [lcdPkg::pixelWidth-1:0]     color,
    input  logic                              seqBusy,
    input  logic                              fifoBusy,
    input  logic                              writerBusy
);

    logic                            live;
    logic                            wrAccept;
    logic                            wrIsReq;
    logic                            rdAccept;
    logic                            statusBusy;
    logic [lcdPkg::axiDataWidth-1:0] readValue;

    // Full-word writes only, wStrb has no effect

    assign wrAccept = live & awValid & wValid & ~seqBusy & ~bValid;
    assign awReady  = wrAccept;
    assign wReady   = wrAccept;
    assign bResp    = 2'b00;    // OKAY

    assign wrIsReq = awAddr inside {lcdPkg::addrColumn, lcdPkg::addrRow,
                                    lcdPkg::addrDisplay, lcdPkg::addrFill};

    assign arReady    = live & ~rValid;
    assign rdAccept   = arValid & arReady;
    assign rResp      = 2'b00;
    assign statusBusy = seqBusy | fifoBusy | writerBusy;

    always_comb begin
        readValue = '0;
        case (arAddr)
            lcdPkg::addrStatus: readValue[0] = statusBusy;
            lcdPkg::addrColor:  readValue[lcdPkg::pixelWidth-1:0] = color;
            default: ;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            live     <= 1'b0;
            bValid   <= 1'b0;
            reqValid <= 1'b0;
            rValid   <= 1'b0;
            color    <= '0;
        end else begin
            live     <= 1'b1;             // Readies open one cycle after reset
            reqValid <= 1'b0;
            if (wrAccept) begin
                bValid   <= 1'b1;
                reqValid <= wrIsReq;
                if (awAddr == lcdPkg::addrColor)
                    color <= wData[lcdPkg::pixelWidth-1:0];
            end else if (bReady) begin
                bValid <= 1'b0;
            end
            if (rdAccept)
                rValid <= 1'b1;
            else if (rReady)
                rValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrAccept) begin
            reqWord <= wData;
            case (awAddr)
                lcdPkg::addrColumn:  reqKind <= lcdPkg::reqColumn;
                lcdPkg::addrRow:     reqKind <= lcdPkg::reqRow;
                lcdPkg::addrDisplay: reqKind <= lcdPkg::reqDisplay;
                default:             reqKind <= lcdPkg::reqFill;
            endcase
        end
        if (rdAccept)
            rData <= readValue;
    end

endmodule

//--- rtl/lcdBusWriter.sv
`timescale 1ns/10ps

module lcdBusWriter (
    input  logic       clk,
    input  logic       rst,
    lcdByteIf.sink     in,
    output logic       csx,
    output logic       dcx,
    output logic       wrx,
    output logic [7:0] data,
    output logic       writerBusy
);

    logic pending;   // Select cycle, strobe follows
    logic closing;   // Byte on the pins ends the frame

    // Take a byte only with wrx high and nothing left to strobe or close
    assign in.ready   = wrx & ~pending & ~closing;
    assign writerBusy = ~csx;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            csx     <= 1'b1;
            dcx     <= 1'b1;
            wrx     <= 1'b1;
            data    <= 8'h00;
            pending <= 1'b0;
            closing <= 1'b0;
        end else if (pending) begin
            wrx     <= 1'b0;                  // Strobe low after select
            pending <= 1'b0;
        end else if (!wrx) begin
            wrx <= 1'b1;                      // Panel latches here
        end else if (closing) begin
            csx     <= 1'b1;
            closing <= 1'b0;
        end else if (in.valid) begin
            data    <= in.data;
            dcx     <= in.dc;
            closing <= in.last;
            if (csx) begin
                csx     <= 1'b0;              // Open frame one cycle ahead of wrx
                pending <= 1'b1;
            end else begin
                wrx <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/lcdByteFifo.sv
`timescale 1ns/10ps

module lcdByteFifo #(
    parameter int depth = lcdPkg::fifoDepth
) (
    input  logic     clk,
    input  logic     rst,
    lcdByteIf.sink   in,
    lcdByteIf.source out,
    output logic     fifoBusy
);

    logic [9:0]                   mem [depth];   // {dc, last, data}
    logic [$clog2(depth)-1:0]     wrPtr;
    logic [$clog2(depth)-1:0]     rdPtr;
    logic [$clog2(depth + 1)-1:0] count;
    logic                         push;
    logic                         pop;

    assign in.ready  = int'(count) != depth;
    assign out.valid = count != '0;
    assign {out.dc, out.last, out.data} = mem[rdPtr];
    assign fifoBusy  = out.valid;

    assign push = in.valid & in.ready;
    assign pop  = out.valid & out.ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wrPtr] <= {in.dc, in.last, in.data};
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push)
                wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- rtl/lcdByteIf.sv
`timescale 1ns/10ps

interface lcdByteIf;

    logic       valid;
    logic       ready;
    logic       dc;      // Low for command, high for parameter
    logic [7:0] data;
    logic       last;    // Final byte of one request

    modport source (
        output valid, dc, data, last,
        input  ready
    );

    modport sink (
        input  valid, dc, data, last,
        output ready
    );

endinterface

//--- rtl/lcdCommandSequencer.sv
`timescale 1ns/10ps

module lcdCommandSequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          reqValid,
    input  lcdPkg::reqKind_e              reqKind,
    input  logic [31:0]                   reqWord,
    input  logic [lcdPkg::pixelWidth-1:0] color,
    output logic                          seqBusy,
    lcdByteIf.source                      out
);

    logic                              busy;
    logic                              inParams;     // Command byte already sent
    logic                              hiByte;       // Next fill byte is the high half
    logic [1:0]                        byteIdx;
    logic [lcdPkg::fillCountWidth-1:0] pixelsLeft;
    lcdPkg::reqKind_e                  kind;
    lcdPkg::windowWord_u               word;
    logic                              isFill;
    logic [7:0]                        cmdByte;
    logic [7:0]                        paramByte;
    logic                              cmdLast;
    logic                              paramLast;

    assign seqBusy = busy;
    assign isFill  = kind == lcdPkg::reqFill;

    always_comb begin
        case (kind)
            lcdPkg::reqColumn:  cmdByte = lcdPkg::cmdColumnSet;
            lcdPkg::reqRow:     cmdByte = lcdPkg::cmdRowSet;
            lcdPkg::reqDisplay: cmdByte = word.bytes[0][0] ? lcdPkg::cmdDisplayOn
                                                           : lcdPkg::cmdDisplayOff;
            default:            cmdByte = lcdPkg::cmdMemWrite;
        endcase
    end

    // Display has no parameters, an empty fill stops after the command
    assign cmdLast = (kind == lcdPkg::reqDisplay) || (isFill && pixelsLeft == '0);

    always_comb begin
        if (isFill) begin
            paramByte = hiByte ? color[15:8] : color[7:0];
            paramLast = !hiByte && pixelsLeft == lcdPkg::fillCountWidth'(1);
        end else begin
            paramByte = word.bytes[byteIdx];    // MSB first
            paramLast = byteIdx == 2'd0;
        end
    end

    assign out.valid = busy;
    assign out.dc    = inParams;
    assign out.data  = inParams ? paramByte : cmdByte;
    assign out.last  = inParams ? paramLast : cmdLast;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            inParams   <= 1'b0;
            hiByte     <= 1'b1;
            byteIdx    <= 2'd3;
            pixelsLeft <= '0;
        end else if (!busy) begin
            if (reqValid) begin
                busy       <= 1'b1;
                inParams   <= 1'b0;
                hiByte     <= 1'b1;
                byteIdx    <= 2'd3;
                pixelsLeft <= reqWord[lcdPkg::fillCountWidth-1:0];
            end
        end else if (out.ready) begin
            if (out.last)
                busy <= 1'b0;
            if (!inParams) begin
                inParams <= 1'b1;
            end else if (isFill) begin
                hiByte <= ~hiByte;
                if (!hiByte)
                    pixelsLeft <= pixelsLeft - 1'b1;  // One pixel per byte pair
            end else begin
                byteIdx <= byteIdx - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && reqValid) begin
            kind <= reqKind;
            word <= reqWord;
        end
    end

endmodule

//--- rtl/lcdController.sv
`timescale 1ns/10ps

module lcdController (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [lcdPkg::axiAddrWidth-1:0]   awAddr,
    input  logic                              awValid,
    output logic                              awReady,
    input  logic [lcdPkg::axiDataWidth-1:0]   wData,
    input  logic [lcdPkg::axiDataWidth/8-1:0] wStrb,
    input  logic                              wValid,
    output logic                              wReady,
    output logic [1:0]                        bResp,
    output logic                              bValid,
    input  logic                              bReady,
    input  logic [lcdPkg::axiAddrWidth-1:0]   arAddr,
    input  logic                              arValid,
    output logic                              arReady,
    output logic [lcdPkg::axiDataWidth-1:0]   rData,
    output logic [1:0]                        rResp,
    output logic                              rValid,
    input  logic                              rReady,
    // Display bus
    output logic                              csx,
    output logic                              dcx,
    output logic                              wrx,
    output logic [7:0]                        data
);

    logic                          reqValid;
    lcdPkg::reqKind_e              reqKind;
    logic [31:0]                   reqWord;
    logic [lcdPkg::pixelWidth-1:0] color;
    logic                          seqBusy;
    logic                          fifoBusy;
    logic                          writerBusy;

    lcdByteIf seqToFifo ();
    lcdByteIf fifoToWriter ();

    lcdAxiRegs axiRegs_i (
        .clk, .rst,
        .awAddr, .awValid, .awReady,
        .wData, .wStrb, .wValid, .wReady,
        .bResp, .bValid, .bReady,
        .arAddr, .arValid, .arReady,
        .rData, .rResp, .rValid, .rReady,
        .reqValid, .reqKind, .reqWord, .color,
        .seqBusy, .fifoBusy, .writerBusy
    );

    lcdCommandSequencer sequencer_i (
        .clk, .rst,
        .reqValid, .reqKind, .reqWord, .color,
        .seqBusy,
        .out (seqToFifo.source)
    );

    lcdByteFifo #(
        .depth (lcdPkg::fifoDepth)
    ) fifo_i (
        .clk, .rst,
        .in       (seqToFifo.sink),
        .out      (fifoToWriter.source),
        .fifoBusy
    );

    lcdBusWriter writer_i (
        .clk, .rst,
        .in (fifoToWriter.sink),
        .csx, .dcx, .wrx, .data,
        .writerBusy
    );

endmodule

//--- rtl/lcdPkg.sv
package lcdPkg;

    // AXI4-Lite bus widths
    localparam int axiAddrWidth = 5;
    localparam int axiDataWidth = 32;

    // Register byte offsets
    localparam logic [4:0] addrColumn  = 5'h00;
    localparam logic [4:0] addrRow     = 5'h04;
    localparam logic [4:0] addrDisplay = 5'h08;
    localparam logic [4:0] addrFill    = 5'h0C;
    localparam logic [4:0] addrColor   = 5'h10;
    localparam logic [4:0] addrStatus  = 5'h14;

    // Panel command bytes
    localparam logic [7:0] cmdColumnSet  = 8'h2A;
    localparam logic [7:0] cmdRowSet     = 8'h2B;
    localparam logic [7:0] cmdMemWrite   = 8'h2C;
    localparam logic [7:0] cmdDisplayOn  = 8'h29;
    localparam logic [7:0] cmdDisplayOff = 8'h28;

    localparam int pixelWidth     = 16;   // RGB565
    localparam int fillCountWidth = 17;   // Up to 240 x 320 pixels
    localparam int fifoDepth      = 8;

    // Request handed from the register slave to the sequencer
    typedef enum logic [1:0] {
        reqColumn,
        reqRow,
        reqDisplay,
        reqFill
    } reqKind_e;

    // Window word of a column or row set
    typedef union packed {
        logic [3:0][7:0] bytes;           // bytes[3] goes out first
        struct packed {
            logic [15:0] startCoord;
            logic [15:0] endCoord;
        } coords;
    } windowWord_u;

endpackage

//--- testbench/lcdControllerTb.sv
`timescale 1ns/10ps

module lcdControllerTb;

    localparam int waitLimit = 2000;    // Cycles allowed per wait loop
    localparam int pollLimit = 500;
    localparam int minGap    = 7;       // Request pulse, five producer bytes, then the next accept

    logic                              clk;
    logic                              rst;
    logic [lcdPkg::axiAddrWidth-1:0]   awAddr;
    logic                              awValid;
    logic                              awReady;
    logic [lcdPkg::axiDataWidth-1:0]   wData;
    logic [lcdPkg::axiDataWidth/8-1:0] wStrb;
    logic                              wValid;
    logic                              wReady;
    logic [1:0]                        bResp;
    logic                              bValid;
    logic                              bReady;
    logic [lcdPkg::axiAddrWidth-1:0]   arAddr;
    logic                              arValid;
    logic                              arReady;
    logic [lcdPkg::axiDataWidth-1:0]   rData;
    logic [1:0]                        rResp;
    logic                              rValid;
    logic                              rReady;
    logic                              csx;
    logic                              dcx;
    logic                              wrx;
    logic [7:0]                        data;

    logic [8:0]  busBytes [$];   // {dcx, data} per strobe
    int          frameCount;
    int          cycle;
    int          lastRespCycle;
    bit          armed;
    logic [31:0] rngState;

    lcdController lcdController_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Panel view of the bus
    always @(posedge wrx) begin
        if (csx === 1'b0)
            busBytes.push_back({dcx, data});
    end

    always @(posedge csx) begin
        if (armed)
            frameCount <= frameCount + 1;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic failRun(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkPin(input string name, input logic got, input logic exp);
        if (got !== exp)
            failRun($sformatf("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic checkResp(input string what, input logic [1:0] got);
        if (got !== 2'b00)
            failRun($sformatf("ERROR at %0d ns: %s response %b, expected OKAY", $time, what, got));
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp)
            failRun($sformatf("ERROR at %0d ns: %s count %0d, expected %0d",
                              $time, what, got, exp));
    endtask

    task automatic checkRead(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            failRun($sformatf("ERROR at %0d ns: %s read %h, expected %h", $time, what, got, exp));
    endtask

    task automatic checkBusByte(input string what, input logic [8:0] got,
                                input logic expDc, input logic [7:0] expByte);
        if (got !== {expDc, expByte})
            failRun($sformatf("ERROR at %0d ns: %s got dc %b byte %h, expected dc %b byte %h",
                              $time, what, got[8], got[7:0], expDc, expByte));
    endtask

    // Coordinates go out start first, high byte before low byte
    task automatic checkWindow(input lcdPkg::windowWord_u exp);
        checkBusByte("start high", busBytes.pop_front(), 1'b1, exp.coords.startCoord[15:8]);
        checkBusByte("start low", busBytes.pop_front(), 1'b1, exp.coords.startCoord[7:0]);
        checkBusByte("end high", busBytes.pop_front(), 1'b1, exp.coords.endCoord[15:8]);
        checkBusByte("end low", busBytes.pop_front(), 1'b1, exp.coords.endCoord[7:0]);
    endtask

    task automatic checkFillBytes(input logic [15:0] colour, input int pixels);
        checkCount("fill bytes", busBytes.size(), 1 + 2 * pixels);
        checkBusByte("fill command", busBytes.pop_front(), 1'b0, lcdPkg::cmdMemWrite);
        for (int i = 0; i < pixels; i++) begin
            checkBusByte("colour high", busBytes.pop_front(), 1'b1, colour[15:8]);
            checkBusByte("colour low", busBytes.pop_front(), 1'b1, colour[7:0]);
        end
    endtask

    task automatic axiWrite(input logic [lcdPkg::axiAddrWidth-1:0] addr, input logic [31:0] value);
        int n;
        awAddr  = addr;
        awValid = 1'b1;
        wData   = value;
        wValid  = 1'b1;
        n = 0;
        do begin
            @(posedge clk);                   // Ready as the edge sees it
            n++;
        end while (!awReady && n < waitLimit);
        if (!awReady)
            failRun("Timed out waiting for the write address to be accepted");
        checkPin("wReady", wReady, 1'b1);
        @(negedge clk);
        checkPin("bValid", bValid, 1'b1);
        lastRespCycle = cycle;
        checkResp("write", bResp);
        awValid = 1'b0;
        wValid  = 1'b0;
        bReady  = 1'b1;
        @(negedge clk);
        bReady = 1'b0;
    endtask

    task automatic axiRead(input logic [lcdPkg::axiAddrWidth-1:0] addr, output logic [31:0] value);
        int n;
        arAddr  = addr;
        arValid = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arReady && n < waitLimit);
        if (!arReady)
            failRun("Timed out waiting for the read address to be accepted");
        @(negedge clk);
        checkPin("rValid", rValid, 1'b1);
        value = rData;
        checkResp("read", rResp);
        arValid = 1'b0;
        rReady  = 1'b1;
        @(negedge clk);
        rReady = 1'b0;
    endtask

    task automatic waitFrames(input int target);
        int n;
        n = 0;
        while (frameCount < target && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (frameCount < target)
            failRun("Timed out waiting for csx to close the display frame");
    endtask

    task automatic testResetValues();
        logic [31:0] status;
        checkPin("csx", csx, 1'b1);
        checkPin("wrx", wrx, 1'b1);
        checkBusByte("idle pins", {dcx, data}, 1'b1, 8'h00);
        checkPin("awReady", awReady, 1'b0);
        checkPin("wReady", wReady, 1'b0);
        checkPin("bValid", bValid, 1'b0);
        checkPin("arReady", arReady, 1'b0);
        checkPin("rValid", rValid, 1'b0);
        axiRead(lcdPkg::addrStatus, status);
        checkRead("status after reset", status, 32'd0);
    endtask

    task automatic testWindowSet(input logic [lcdPkg::axiAddrWidth-1:0] addr, input logic [7:0] cmd);
        lcdPkg::windowWord_u word;
        int                  start;
        word = nextRandom();
        busBytes.delete();
        start = frameCount;
        axiWrite(addr, word);
        waitFrames(start + 1);
        checkCount("window bytes", busBytes.size(), 5);
        checkBusByte("window command", busBytes.pop_front(), 1'b0, cmd);
        checkWindow(word);
    endtask

    task automatic testDisplay(input bit on);
        int start;
        busBytes.delete();
        start = frameCount;
        axiWrite(lcdPkg::addrDisplay, {31'd0, on});
        waitFrames(start + 1);
        checkCount("display bytes", busBytes.size(), 1);
        checkBusByte("display command", busBytes.pop_front(), 1'b0,
                     on ? lcdPkg::cmdDisplayOn : lcdPkg::cmdDisplayOff);
    endtask

    task automatic testFill();
        logic [31:0] rnd;
        logic [31:0] readBack;
        int          start;
        rnd = nextRandom();
        axiWrite(lcdPkg::addrColor, rnd);
        axiRead(lcdPkg::addrColor, readBack);
        checkRead("colour", readBack, {16'd0, rnd[15:0]});
        busBytes.delete();
        start = frameCount;
        axiWrite(lcdPkg::addrFill, 32'd5);
        waitFrames(start + 1);
        checkFillBytes(rnd[15:0], 5);
    endtask

    task automatic testBusyPoll();
        logic [31:0] rnd;
        logic [31:0] status;
        int          start;
        int          polls;
        rnd = nextRandom();
        axiWrite(lcdPkg::addrColor, rnd);
        busBytes.delete();
        start = frameCount;
        axiWrite(lcdPkg::addrFill, 32'd40);
        axiRead(lcdPkg::addrStatus, status);
        checkRead("status during fill", status, 32'd1);
        polls = 0;
        while (status[0] && polls < pollLimit) begin
            axiRead(lcdPkg::addrStatus, status);
            polls++;
        end
        if (status[0])
            failRun("Status stayed busy after the fill should have ended");
        checkCount("fill frames", frameCount - start, 1);
        checkFillBytes(rnd[15:0], 40);
    endtask

    task automatic testBackToBack();
        lcdPkg::windowWord_u colWord;
        lcdPkg::windowWord_u rowWord;
        int                  start;
        int                  firstResp;
        colWord = nextRandom();
        rowWord = nextRandom();
        busBytes.delete();
        start = frameCount;
        axiWrite(lcdPkg::addrColumn, colWord);
        firstResp = lastRespCycle;
        axiWrite(lcdPkg::addrRow, rowWord);
        if (lastRespCycle - firstResp < minGap)
            failRun($sformatf("ERROR at %0d ns: second response after %0d cycles, minimum %0d",
                              $time, lastRespCycle - firstResp, minGap));
        waitFrames(start + 2);
        checkCount("back-to-back bytes", busBytes.size(), 10);
        checkBusByte("first command", busBytes.pop_front(), 1'b0, lcdPkg::cmdColumnSet);
        checkWindow(colWord);
        checkBusByte("second command", busBytes.pop_front(), 1'b0, lcdPkg::cmdRowSet);
        checkWindow(rowWord);
    endtask

    initial begin
        rngState = 32'h4f19_a8ab;
        rst      = 1'b1;
        awAddr   = '0;
        awValid  = 1'b0;
        wData    = '0;
        wStrb    = '1;
        wValid   = 1'b0;
        bReady   = 1'b0;
        arAddr   = '0;
        arValid  = 1'b0;
        rReady   = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst   = 1'b0;
        armed = 1'b1;

        testResetValues();
        testWindowSet(lcdPkg::addrColumn, lcdPkg::cmdColumnSet);
        testWindowSet(lcdPkg::addrRow, lcdPkg::cmdRowSet);
        testDisplay(1'b1);
        testDisplay(1'b0);
        testFill();
        testBusyPoll();
        testBackToBack();

        $display("All checks passed");
        $finish;
    end

endmodule
